// ==== sys_arr.f ====
src/sys_arr_pkg.sv
src/row_link_if.sv
src/pe.sv
src/sys_arr_row.sv
src/sys_arr_grid.sv
src/data_skew.sv
src/sum_deskew.sv
src/sys_arr_top.sv
test/tb_sys_arr.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the sys_arr testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_sys_arr \
    -Mdir obj_dir \
    -f sys_arr.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_sys_arr)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== test/tb_sys_arr.sv ====
module tb_sys_arr;
    timeunit 1ns;
    timeprecision 1ps;

    import sys_arr_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 6;
    localparam int MAX_VEC      = 12;
    localparam logic [31:0] SEED = 32'h41a3_ba8c;

    // Per test: weight load, one gap and one vector per slot, drain and idle tail
    localparam int TEST_CYCLES    = DIM + 2 + 2 * MAX_VEC + LATENCY + 4;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 + NUM_TESTS * TEST_CYCLES + 64;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  in_valid;
    logic [DIM*DATA_W-1:0] in_data;
    logic                  w_load;
    logic [WEIGHT_BUS_W-1:0] w_row;
    logic                  out_valid;
    logic [SUM_BUS_W-1:0]  out_data;

    // Stimulus table, one row per test
    string                                   tab_name [NUM_TESTS];
    bit                                      tab_load [NUM_TESTS];  // Load weights first
    logic [DIM-1:0][DIM-1:0][DATA_W-1:0]     tab_w    [NUM_TESTS];  // tab_w[t][r][c]
    int                                      tab_nvec [NUM_TESTS];
    logic [MAX_VEC-1:0]                      tab_gap  [NUM_TESTS];  // Idle cycle before vector
    logic [MAX_VEC-1:0][DIM-1:0][DATA_W-1:0] tab_x    [NUM_TESTS];  // Lane r in byte r

    // Weights the DUT should hold right now
    logic [DIM-1:0][DIM-1:0][DATA_W-1:0] cur_w;

    // Results still to come and the cycle each one is due
    logic [SUM_BUS_W-1:0] exp_q[$];
    int                   due_q[$];

    int cycle;
    int err_count;
    int checked;
    int tests_passed;
    int tests_failed;
    int err_before;
    int checked_before;
    int watchdog_cycles;

    sys_arr_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .w_load    (w_load),
        .w_row     (w_row),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic [DATA_W-1:0] rand_byte();
        logic [31:0] r;
        r = $urandom();
        return r[DATA_W-1:0];
    endfunction

    // Column c is the sum over r of x[r] * w[r][c], kept modulo 2^16
    function automatic logic [SUM_BUS_W-1:0] expected_sums(
        input logic [DIM-1:0][DATA_W-1:0]          x,
        input logic [DIM-1:0][DIM-1:0][DATA_W-1:0] w
    );
        logic [SUM_BUS_W-1:0] sums;
        int acc;
        int xv;
        int wv;
        sums = '0;
        for (int c = 0; c < DIM; c++) begin
            acc = 0;
            for (int r = 0; r < DIM; r++) begin
                xv = int'($signed(x[r]));
                wv = int'($signed(w[r][c]));
                acc = acc + xv * wv;
            end
            sums[c*SUM_W +: SUM_W] = acc[SUM_W-1:0];
        end
        return sums;
    endfunction

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            tab_load[t] = 1'b1;
            tab_w[t]    = '0;
            tab_nvec[t] = 0;
            tab_gap[t]  = '0;
            tab_x[t]    = '0;
        end

        // Weights are still zero from reset
        tab_name[0]  = "reset_zero";
        tab_load[0]  = 1'b0;
        tab_nvec[0]  = 1;
        tab_x[0][0]  = {8'h04, 8'h03, 8'h02, 8'h01};

        // Row r routes lane r to column r+1, wrapping
        tab_name[1] = "permute";
        for (int r = 0; r < DIM; r++) begin
            tab_w[1][r][(r + 1) % DIM] = 8'h01;
        end
        tab_nvec[1] = 1;
        tab_x[1][0] = {8'h44, 8'hfd, 8'h22, 8'h11};

        tab_name[2] = "back_to_back";
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                tab_w[2][r][c] = rand_byte();
            end
        end
        tab_nvec[2] = 12;
        for (int v = 0; v < 12; v++) begin
            for (int r = 0; r < DIM; r++) begin
                tab_x[2][v][r] = rand_byte();
            end
        end

        tab_name[3] = "gaps";
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                tab_w[3][r][c] = rand_byte();
            end
        end
        tab_nvec[3] = 8;
        tab_gap[3]  = 12'b0000_1011_0110;
        for (int v = 0; v < 8; v++) begin
            for (int r = 0; r < DIM; r++) begin
                tab_x[3][v][r] = rand_byte();
            end
        end

        // Even columns hold -128, odd columns +127
        tab_name[4] = "extremes";
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                tab_w[4][r][c] = (c % 2 == 0) ? 8'h80 : 8'h7f;
            end
        end
        tab_nvec[4] = 4;
        tab_x[4][0] = {8'h80, 8'h80, 8'h80, 8'h80};  // 4 * 16384 wraps to zero
        tab_x[4][1] = {8'h00, 8'hff, 8'h80, 8'h7f};
        tab_x[4][2] = {8'h7f, 8'h7f, 8'h7f, 8'h7f};
        tab_x[4][3] = {8'h7f, 8'h80, 8'h7f, 8'h80};

        tab_name[5] = "reload";
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                tab_w[5][r][c] = rand_byte();
            end
        end
        tab_nvec[5] = 6;
        tab_gap[5]  = 12'b0000_0000_1000;
        for (int v = 0; v < 6; v++) begin
            for (int r = 0; r < DIM; r++) begin
                tab_x[5][v][r] = rand_byte();
            end
        end
    endtask

    // Compare the outputs against the result due in this cycle, if any
    task automatic check_outputs();
        logic [SUM_BUS_W-1:0] exp_word;
        logic [SUM_W-1:0]     exp_col;
        logic [SUM_W-1:0]     got_col;
        int                   due;
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            exp_word = exp_q.pop_front();
            due      = due_q.pop_front();
            if (out_valid !== 1'b1) begin
                $display("Missing out_valid for the result due at cycle %0d", due);
                err_count++;
            end else begin
                checked++;
                for (int c = 0; c < DIM; c++) begin
                    exp_col = exp_word[c*SUM_W +: SUM_W];
                    got_col = out_data[c*SUM_W +: SUM_W];
                    if (got_col !== exp_col) begin
                        $display("Fail out_data[%0d] cycle %0d: expected %h, got %h",
                                 c, cycle, exp_col, got_col);
                        err_count++;
                    end
                end
            end
        end else if (out_valid !== 1'b0) begin
            $display("Unexpected out_valid at cycle %0d with no result due", cycle);
            err_count++;
        end
    endtask

    // Outputs are checked and inputs changed on the falling edge
    task automatic tick();
        @(negedge clk);
        cycle = cycle + 1;
        check_outputs();
    endtask

    // Last row first, so the first row given ends up in row 3
    task automatic load_weights(input int t);
        for (int i = DIM - 1; i >= 0; i--) begin
            tick();
            w_load = 1'b1;
            w_row  = tab_w[t][i];
        end
        tick();
        w_load = 1'b0;
        w_row  = '0;
        cur_w  = tab_w[t];
    endtask

    task automatic stream_vectors(input int t);
        for (int v = 0; v < tab_nvec[t]; v++) begin
            if (tab_gap[t][v]) begin
                tick();
                in_valid = 1'b0;
                in_data  = '0;
            end
            tick();
            in_valid = 1'b1;
            in_data  = tab_x[t][v];
            exp_q.push_back(expected_sums(tab_x[t][v], cur_w));
            due_q.push_back(cycle + LATENCY + 1);  // First falling edge after edge k+8
        end
        tick();
        in_valid = 1'b0;
        in_data  = '0;
    endtask

    // Wait for every queued result, then watch a little longer for strays
    task automatic drain();
        while (due_q.size() > 0) begin
            tick();
        end
        repeat (2) tick();
    endtask

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        w_load       = 1'b0;
        w_row        = '0;
        cur_w        = '0;
        cycle        = 0;
        err_count    = 0;
        checked      = 0;
        tests_passed = 0;
        tests_failed = 0;

        void'($urandom(SEED));
        build_table();

        repeat (RESET_CYCLES) tick();  // out_valid must stay low throughout
        rst_n = 1'b1;
        repeat (4) tick();

        for (int t = 0; t < NUM_TESTS; t++) begin
            err_before     = err_count;
            checked_before = checked;
            if (tab_load[t]) begin
                load_weights(t);
            end
            stream_vectors(t);
            drain();
            if (err_count == err_before && checked - checked_before == tab_nvec[t]) begin
                tests_passed++;
                $display("Test %0d %s: ok, %0d results checked",
                         t, tab_name[t], checked - checked_before);
            end else begin
                tests_failed++;
                $display("Test %0d %s: failed, %0d results checked, %0d errors",
                         t, tab_name[t], checked - checked_before, err_count - err_before);
            end
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d results, %0d errors",
                 NUM_TESTS, tests_passed, tests_failed, checked, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        watchdog_cycles = 0;
        while (watchdog_cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            watchdog_cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== src/sys_arr_top.sv ====
module sys_arr_top (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        in_valid,
    input  logic [sys_arr_pkg::DIM*sys_arr_pkg::DATA_W-1:0] in_data,  // Lane r feeds row r
    input  logic                                        w_load,
    input  logic [sys_arr_pkg::WEIGHT_BUS_W-1:0]        w_row,    // Column c in byte c
    output logic                                        out_valid,
    output logic [sys_arr_pkg::SUM_BUS_W-1:0]           out_data  // Column c in word c
);
    import sys_arr_pkg::*;

    logic [DIM-1:0]          row_active;
    logic [DIM*DATA_W-1:0]   row_data;
    logic [DIM-1:0]          top_wwrite;
    logic [SUM_BUS_W-1:0]    bottom_macc;
    logic [DIM-1:0]          bottom_active;

    // One load strobe shifts every column at once
    assign top_wwrite = {DIM{w_load}};

    data_skew u_skew (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .row_active (row_active),
        .row_data   (row_data)
    );

    sys_arr_grid u_grid (
        .clk           (clk),
        .rst_n         (rst_n),
        .row_active    (row_active),
        .row_data      (row_data),
        .top_w         (w_row),
        .top_wwrite    (top_wwrite),
        .bottom_macc   (bottom_macc),
        .bottom_active (bottom_active)
    );

    sum_deskew u_deskew (
        .clk        (clk),
        .rst_n      (rst_n),
        .col_macc   (bottom_macc),
        .col_active (bottom_active),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

// ==== src/sum_deskew.sv ====
module sum_deskew (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [sys_arr_pkg::SUM_BUS_W-1:0] col_macc,
    input  logic [sys_arr_pkg::DIM-1:0]       col_active,
    output logic                              out_valid,
    output logic [sys_arr_pkg::SUM_BUS_W-1:0] out_data
);
    import sys_arr_pkg::*;

    // Column c leaves the grid c cycles after column 0
    // Delaying it DIM-1-c more lines all columns up with the last one,
    // and the output register brings the total to LATENCY
    logic [SUM_BUS_W-1:0] aligned;

    for (genvar c = 0; c < DIM; c++) begin : g_col
        if (c == DIM - 1) begin : g_direct
            assign aligned[c*SUM_W +: SUM_W] = col_macc[c*SUM_W +: SUM_W];
        end else begin : g_delay
            logic [DIM-2-c:0][SUM_W-1:0] pipe;

            always_ff @(posedge clk) begin
                pipe[0] <= col_macc[c*SUM_W +: SUM_W];
                for (int i = 1; i <= DIM - 2 - c; i++) begin
                    pipe[i] <= pipe[i-1];
                end
            end

            assign aligned[c*SUM_W +: SUM_W] = pipe[DIM-2-c];
        end
    end

    // Last column needs no delay, its flag marks the whole aligned row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= col_active[DIM-1];
        end
    end

    always_ff @(posedge clk) begin
        out_data <= aligned;
    end

endmodule

// ==== src/data_skew.sv ====
module data_skew (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        in_valid,
    input  logic [sys_arr_pkg::DIM*sys_arr_pkg::DATA_W-1:0] in_data,
    output logic [sys_arr_pkg::DIM-1:0]                 row_active,
    output logic [sys_arr_pkg::DIM*sys_arr_pkg::DATA_W-1:0] row_data
);
    import sys_arr_pkg::*;

    // Lane r: input register then r skew stages, so row r lags row 0 by r
    for (genvar r = 0; r < DIM; r++) begin : g_lane
        logic [r:0]             v_q;  // Valid copy for this lane
        logic [r:0][DATA_W-1:0] d_q;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                v_q <= '0;
            end else begin
                v_q[0] <= in_valid;
                for (int i = 1; i <= r; i++) begin
                    v_q[i] <= v_q[i-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            d_q[0] <= in_data[r*DATA_W +: DATA_W];
            for (int i = 1; i <= r; i++) begin
                d_q[i] <= d_q[i-1];
            end
        end

        assign row_active[r]                 = v_q[r];
        assign row_data[r*DATA_W +: DATA_W]  = d_q[r];
    end

endmodule

// ==== src/sys_arr_grid.sv ====
module sys_arr_grid (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [sys_arr_pkg::DIM-1:0]                 row_active,
    input  logic [sys_arr_pkg::DIM*sys_arr_pkg::DATA_W-1:0] row_data,
    input  logic [sys_arr_pkg::WEIGHT_BUS_W-1:0]        top_w,
    input  logic [sys_arr_pkg::DIM-1:0]                 top_wwrite,
    output logic [sys_arr_pkg::SUM_BUS_W-1:0]           bottom_macc,
    output logic [sys_arr_pkg::DIM-1:0]                 bottom_active
);
    import sys_arr_pkg::*;

    // Link r runs from row r to row r+1, the last one is the bottom edge
    row_link_if #(.cols(DIM)) link [DIM] ();

    // What each row sees on its upper edge
    logic [DIM-1:0][WEIGHT_BUS_W-1:0] row_win;
    logic [DIM-1:0][SUM_BUS_W-1:0]    row_sumin;
    logic [DIM-1:0][DIM-1:0]          row_wwrite;

    for (genvar r = 0; r < DIM; r++) begin : g_row
        if (r == 0) begin : g_top
            assign row_win[r]    = top_w;
            assign row_sumin[r]  = '0;  // Sums start from zero
            assign row_wwrite[r] = top_wwrite;
        end else begin : g_below
            assign row_win[r]    = link[r-1].w;
            assign row_sumin[r]  = link[r-1].macc;
            assign row_wwrite[r] = link[r-1].wwrite;
        end

        sys_arr_row #(.row_width(DIM)) u_row (
            .clk     (clk),
            .rst_n   (rst_n),
            .active  (row_active[r]),
            .datain  (row_data[r*DATA_W +: DATA_W]),
            .win     (row_win[r]),
            .sumin   (row_sumin[r]),
            .wwrite  (row_wwrite[r]),
            .link    (link[r]),
            .dataout ()  // Data falls off the right edge
        );
    end

    assign bottom_macc   = link[DIM-1].macc;
    assign bottom_active = link[DIM-1].active;

endmodule

// ==== src/sys_arr_row.sv ====
module sys_arr_row #(
    parameter int row_width = sys_arr_pkg::DIM
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    active,
    input  logic [sys_arr_pkg::DATA_W-1:0]          datain,  // Left edge of the row
    input  logic [row_width*sys_arr_pkg::DATA_W-1:0] win,
    input  logic [row_width*sys_arr_pkg::SUM_W-1:0]  sumin,
    input  logic [row_width-1:0]                    wwrite,
    row_link_if.up                                  link,    // Towards the row below
    output logic [sys_arr_pkg::DATA_W-1:0]          dataout  // Right edge of the row
);
    import sys_arr_pkg::*;

    // Left to right chain, entry 0 is the row input
    logic [row_width:0]             act_chain;
    logic [row_width:0][DATA_W-1:0] data_chain;

    // Column outputs gathered for the link
    logic [row_width*SUM_W-1:0]  macc_bus;
    logic [row_width*DATA_W-1:0] w_bus;
    logic [row_width-1:0]        wwrite_bus;

    assign act_chain[0]  = active;
    assign data_chain[0] = datain;
    assign dataout       = data_chain[row_width];

    for (genvar i = 0; i < row_width; i++) begin : g_pe
        pe u_pe (
            .clk       (clk),
            .rst_n     (rst_n),
            .active    (act_chain[i]),
            .datain    (data_chain[i]),
            .win       (win[i*DATA_W +: DATA_W]),
            .sumin     (sumin[i*SUM_W +: SUM_W]),
            .wwrite    (wwrite[i]),
            .maccout   (macc_bus[i*SUM_W +: SUM_W]),
            .dataout   (data_chain[i+1]),
            .wout      (w_bus[i*DATA_W +: DATA_W]),
            .wwriteout (wwrite_bus[i]),
            .activeout (act_chain[i+1])
        );
    end

    assign link.macc   = macc_bus;
    assign link.w      = w_bus;
    assign link.wwrite = wwrite_bus;
    assign link.active = act_chain[row_width:1];  // Each PE flags its own sum

endmodule

// ==== src/pe.sv ====
module pe (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  active,
    input  logic signed [sys_arr_pkg::DATA_W-1:0] datain,
    input  logic signed [sys_arr_pkg::DATA_W-1:0] win,
    input  logic signed [sys_arr_pkg::SUM_W-1:0]  sumin,
    input  logic                                  wwrite,
    output logic signed [sys_arr_pkg::SUM_W-1:0]  maccout,
    output logic signed [sys_arr_pkg::DATA_W-1:0] dataout,
    output logic signed [sys_arr_pkg::DATA_W-1:0] wout,
    output logic                                  wwriteout,
    output logic                                  activeout
);
    import sys_arr_pkg::*;

    logic signed [DATA_W-1:0] weight_q;  // Stationary weight
    logic signed [SUM_W-1:0]  product;

    // 8x8 signed product always fits in 16 bits
    assign product = datain * weight_q;

    // Weight chain is combinational so one strobe moves a whole column down
    assign wout      = weight_q;
    assign wwriteout = wwrite;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            weight_q <= '0;
        end else if (wwrite) begin
            weight_q <= win;  // Take the weight from the row above
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            maccout   <= '0;
            activeout <= 1'b0;
        end else begin
            if (active) begin
                maccout <= sumin + product;  // Wraps on overflow
            end else begin
                maccout <= sumin;
            end
            activeout <= active;
        end
    end

    // Data moves one column right per cycle
    always_ff @(posedge clk) begin
        dataout <= datain;
    end

endmodule

// ==== src/row_link_if.sv ====
// Vertical link between two rows of the array
interface row_link_if #(
    parameter int cols = sys_arr_pkg::DIM
);
    import sys_arr_pkg::*;

    logic [cols*SUM_W-1:0]  macc;    // Partial sums, column c in word c
    logic [cols*DATA_W-1:0] w;       // Weights shifting down
    logic [cols-1:0]        wwrite;  // Per-column weight strobes
    logic [cols-1:0]        active;  // Sum valid per column

    // Row above drives the link
    modport up (
        output macc, w, wwrite, active
    );

    // Row below takes it
    modport down (
        input macc, w, wwrite, active
    );

endinterface

// ==== src/sys_arr_pkg.sv ====
package sys_arr_pkg;

    // Square array, rows equal columns
    localparam int DIM = 4;

    // Input data and weights are signed bytes
    localparam int DATA_W = 8;

    // Partial sums and results are signed and wrap modulo 2^16
    localparam int SUM_W = 16;

    localparam int WEIGHT_BUS_W = DIM * DATA_W;  // One row of weights
    localparam int SUM_BUS_W    = DIM * SUM_W;   // One row of sums

    // After the input edge: DIM rows, DIM-1 cycles of column skew or deskew
    // and the output register add up to this many cycles
    localparam int LATENCY = 2 * DIM;

endpackage
